/* source/mem_pkg.sv */
package mem_pkg;

    // byte address on both cache ports and on burst memory
    localparam int ADDR_WIDTH = 32;

    // one memory beat
    localparam int BEAT_WIDTH = 64;

    // beats that make up one cache line
    localparam int BURSTS_PER_LINE = 4;

    localparam int LINE_WIDTH = BEAT_WIDTH * BURSTS_PER_LINE;   // 256

    // low address bits that are zero in a line address
    localparam int LINE_OFFSET_BITS = 5;

    localparam int BEAT_IDX_BITS = $clog2(BURSTS_PER_LINE);

    // byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // one beat on the memory bus
    typedef logic [BEAT_WIDTH-1:0] beat_t;

    // full line, beat 0 in the low bits
    typedef logic [LINE_WIDTH-1:0] line_t;

    // beat position inside a burst
    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

    // index of the last beat of a burst
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BURSTS_PER_LINE - 1);

endpackage : mem_pkg

/* source/burst_reader.sv */
module burst_reader (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  mem_pkg::addr_t      addr_i,
    input  logic                bmem_ready_i,
    input  mem_pkg::addr_t      bmem_raddr_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i,
    output logic                bmem_read_o,
    output mem_pkg::addr_t      bmem_read_addr_o,
    output mem_pkg::line_t      line_o,
    output logic                done_o
);

    typedef enum logic [1:0] {
        s_idle,
        s_wait,     // started, memory not ready yet
        s_collect
    } rd_state_e;

    rd_state_e          state_q;
    mem_pkg::addr_t     addr_q;
    mem_pkg::line_t     line_q;
    mem_pkg::beat_idx_t beat_q;
    logic               done_q;
    logic               issue;

    // read may leave in the start cycle itself if memory is ready
    assign issue = ((state_q == s_idle && start_i) || state_q == s_wait) && bmem_ready_i;

    assign bmem_read_o      = issue;
    assign bmem_read_addr_o = (state_q == s_idle) ? addr_i : addr_q;
    assign line_o           = line_q;
    assign done_o           = done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= s_idle;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (start_i) begin
                        state_q <= issue ? s_collect : s_wait;
                        beat_q  <= '0;
                    end
                end
                s_wait: begin
                    if (issue) begin
                        state_q <= s_collect;
                    end
                end
                s_collect: begin
                    if (bmem_rvalid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == mem_pkg::LAST_BEAT) begin
                            done_q  <= 1'b1;   // one cycle after the fourth beat
                            state_q <= s_idle;
                        end
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // beats shift in from the top, beat 0 ends up lowest
    always_ff @(posedge clk) begin
        if (state_q == s_idle && start_i) begin
            addr_q <= addr_i;
        end
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[mem_pkg::LINE_WIDTH-1:mem_pkg::BEAT_WIDTH]};
        end
    end

    a_raddr_match: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> bmem_raddr_i == addr_q)
        else $error("read beat returned for a different line");

    a_no_stray_beat: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> state_q == s_collect)
        else $error("read beat arrived with no read outstanding");

endmodule : burst_reader

/* source/burst_writer.sv */
module burst_writer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  mem_pkg::addr_t      addr_i,
    input  mem_pkg::line_t      line_i,
    input  logic                bmem_ready_i,
    output logic                bmem_write_o,
    output mem_pkg::addr_t      bmem_write_addr_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    output logic                done_o
);

    typedef enum logic {
        s_idle,
        s_send
    } wr_state_e;

    wr_state_e          state_q;
    mem_pkg::addr_t     addr_q;
    mem_pkg::line_t     line_q;
    mem_pkg::beat_idx_t beat_q;
    logic               done_q;
    logic               accept;

    // beat only moves on when memory takes it
    assign accept = (state_q == s_send) && bmem_ready_i;

    assign bmem_write_o      = (state_q == s_send);
    assign bmem_write_addr_o = addr_q;    // line address on every beat
    assign bmem_wdata_o      = line_q[beat_q * mem_pkg::BEAT_WIDTH +: mem_pkg::BEAT_WIDTH];
    assign done_o            = done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= s_idle;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                s_idle: begin
                    if (start_i) begin
                        state_q <= s_send;
                        beat_q  <= '0;
                    end
                end
                s_send: begin
                    if (accept) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == mem_pkg::LAST_BEAT) begin
                            done_q  <= 1'b1;
                            state_q <= s_idle;
                        end
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // line held for the whole burst
    always_ff @(posedge clk) begin
        if (state_q == s_idle && start_i) begin
            addr_q <= addr_i;
            line_q <= line_i;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start_i |-> state_q == s_idle)
        else $error("write started while a burst is still going out");

endmodule : burst_writer

/* source/line_arbiter.sv */
module line_arbiter (
    input  logic                clk,
    input  logic                rst,

    // instruction side
    input  mem_pkg::addr_t      i_addr_i,
    input  logic                i_read_i,
    output mem_pkg::line_t      i_rdata_o,
    output logic                i_resp_o,

    // data side
    input  mem_pkg::addr_t      d_addr_i,
    input  logic                d_read_i,
    input  logic                d_write_i,
    input  mem_pkg::line_t      d_wdata_i,
    output mem_pkg::line_t      d_rdata_o,
    output logic                d_resp_o,

    // reader and writer control
    output logic                rd_start_o,
    output logic                wr_start_o,
    output mem_pkg::addr_t      xfer_addr_o,
    output mem_pkg::line_t      wr_line_o,
    input  logic                rd_done_i,
    input  logic                wr_done_i,
    input  mem_pkg::line_t      rd_line_i
);

    typedef enum logic [2:0] {
        s_idle,
        s_i_read,
        s_d_read,
        s_d_write,
        s_respond   // response pulse, then back to idle
    } arb_state_e;

    arb_state_e     state_q;
    arb_state_e     state_d;
    logic           grant_i_rd;
    logic           grant_d_rd;
    logic           grant_d_wr;
    logic           rd_start_q;
    logic           wr_start_q;
    logic           i_resp_q;
    logic           d_resp_q;
    mem_pkg::addr_t addr_q;
    mem_pkg::line_t wr_line_q;
    mem_pkg::line_t i_rdata_q;
    mem_pkg::line_t d_rdata_q;

    // data side wins when both are pending
    always_comb begin
        grant_i_rd = 1'b0;
        grant_d_rd = 1'b0;
        grant_d_wr = 1'b0;
        if (state_q == s_idle) begin
            if (d_write_i) begin
                grant_d_wr = 1'b1;
            end else if (d_read_i) begin
                grant_d_rd = 1'b1;
            end else if (i_read_i) begin
                grant_i_rd = 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (grant_d_wr)      state_d = s_d_write;
                else if (grant_d_rd) state_d = s_d_read;
                else if (grant_i_rd) state_d = s_i_read;
            end
            s_i_read:  if (rd_done_i) state_d = s_respond;
            s_d_read:  if (rd_done_i) state_d = s_respond;
            s_d_write: if (wr_done_i) state_d = s_respond;
            s_respond: state_d = s_idle;    // request still high here, skip it
            default:   state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= s_idle;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            i_resp_q   <= 1'b0;
            d_resp_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            rd_start_q <= grant_d_rd | grant_i_rd;
            wr_start_q <= grant_d_wr;
            i_resp_q   <= (state_q == s_i_read) && rd_done_i;
            d_resp_q   <= ((state_q == s_d_read) && rd_done_i) ||
                          ((state_q == s_d_write) && wr_done_i);
        end
    end

    // held from grant to response
    always_ff @(posedge clk) begin
        if (grant_i_rd || grant_d_rd || grant_d_wr) begin
            addr_q <= grant_i_rd ? i_addr_i : d_addr_i;
        end
        if (grant_d_wr) begin
            wr_line_q <= d_wdata_i;
        end
        if (state_q == s_i_read && rd_done_i) begin
            i_rdata_q <= rd_line_i;
        end
        if (state_q == s_d_read && rd_done_i) begin
            d_rdata_q <= rd_line_i;
        end
    end

    assign rd_start_o  = rd_start_q;
    assign wr_start_o  = wr_start_q;
    assign xfer_addr_o = addr_q;
    assign wr_line_o   = wr_line_q;
    assign i_resp_o    = i_resp_q;
    assign d_resp_o    = d_resp_q;
    assign i_rdata_o   = i_rdata_q;
    assign d_rdata_o   = d_rdata_q;

    a_i_aligned: assert property (@(posedge clk) disable iff (rst)
        i_read_i |-> i_addr_i[mem_pkg::LINE_OFFSET_BITS-1:0] == '0)
        else $error("instruction side request not line aligned");

    a_d_aligned: assert property (@(posedge clk) disable iff (rst)
        (d_read_i || d_write_i) |-> d_addr_i[mem_pkg::LINE_OFFSET_BITS-1:0] == '0)
        else $error("data side request not line aligned");

    a_d_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(d_read_i && d_write_i))
        else $error("data side read and write raised together");

endmodule : line_arbiter

/* source/cache_mem_ctrl.sv */
module cache_mem_ctrl (
    input  logic                clk,
    input  logic                rst,

    input  mem_pkg::addr_t      i_addr_i,
    input  logic                i_read_i,
    output mem_pkg::line_t      i_rdata_o,
    output logic                i_resp_o,

    input  mem_pkg::addr_t      d_addr_i,
    input  logic                d_read_i,
    input  logic                d_write_i,
    input  mem_pkg::line_t      d_wdata_i,
    output mem_pkg::line_t      d_rdata_o,
    output logic                d_resp_o,

    output mem_pkg::addr_t      bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output mem_pkg::beat_t      bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  mem_pkg::addr_t      bmem_raddr_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i
);

    logic           rd_start;
    logic           wr_start;
    logic           rd_done;
    logic           wr_done;
    mem_pkg::addr_t xfer_addr;
    mem_pkg::addr_t rd_addr;
    mem_pkg::addr_t wr_addr;
    mem_pkg::line_t wr_line;
    mem_pkg::line_t rd_line;

    // only one transfer in flight, strobes never overlap
    assign bmem_addr_o = bmem_write_o ? wr_addr : rd_addr;

    line_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_addr_i    (i_addr_i),
        .i_read_i    (i_read_i),
        .i_rdata_o   (i_rdata_o),
        .i_resp_o    (i_resp_o),
        .d_addr_i    (d_addr_i),
        .d_read_i    (d_read_i),
        .d_write_i   (d_write_i),
        .d_wdata_i   (d_wdata_i),
        .d_rdata_o   (d_rdata_o),
        .d_resp_o    (d_resp_o),
        .rd_start_o  (rd_start),
        .wr_start_o  (wr_start),
        .xfer_addr_o (xfer_addr),
        .wr_line_o   (wr_line),
        .rd_done_i   (rd_done),
        .wr_done_i   (wr_done),
        .rd_line_i   (rd_line)
    );

    burst_reader u_reader (
        .clk              (clk),
        .rst              (rst),
        .start_i          (rd_start),
        .addr_i           (xfer_addr),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_raddr_i     (bmem_raddr_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .bmem_read_o      (bmem_read_o),
        .bmem_read_addr_o (rd_addr),
        .line_o           (rd_line),
        .done_o           (rd_done)
    );

    burst_writer u_writer (
        .clk               (clk),
        .rst               (rst),
        .start_i           (wr_start),
        .addr_i            (xfer_addr),
        .line_i            (wr_line),
        .bmem_ready_i      (bmem_ready_i),
        .bmem_write_o      (bmem_write_o),
        .bmem_write_addr_o (wr_addr),
        .bmem_wdata_o      (bmem_wdata_o),
        .done_o            (wr_done)
    );

endmodule : cache_mem_ctrl

/* tests/bmem_model.sv */
module bmem_model (
    input  logic            clk,
    input  logic            rst,
    input  mem_pkg::addr_t  addr_i,
    input  logic            read_i,
    input  logic            write_i,
    input  mem_pkg::beat_t  wdata_i,
    input  logic            heavy_drop_i,   // ready low about half the time
    output logic            ready_o,
    output mem_pkg::addr_t  raddr_o,
    output mem_pkg::beat_t  rdata_o,
    output logic            rvalid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    mem_pkg::line_t mem [mem_pkg::addr_t];
    logic [31:0]    lfsr_q = 32'h19e5_44a8;
    mem_pkg::addr_t rd_addr;
    mem_pkg::line_t rd_line;
    mem_pkg::line_t wr_line;
    logic           rd_busy;
    int             wait_cnt;
    int             rd_beat;
    int             wr_beat;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // unwritten lines read back as line number * 4 + beat, in both halves
    function automatic mem_pkg::line_t stored_line(input mem_pkg::addr_t addr);
        mem_pkg::line_t line;
        logic [31:0]    word;
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        for (int b = 0; b < mem_pkg::BURSTS_PER_LINE; b++) begin
            word = (addr >> mem_pkg::LINE_OFFSET_BITS) * 4 + b;
            line[b*mem_pkg::BEAT_WIDTH +: mem_pkg::BEAT_WIDTH] = {word, word};
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ready_o  <= 1'b0;
            rvalid_o <= 1'b0;
            raddr_o  <= '0;
            rdata_o  <= '0;
            rd_busy  = 1'b0;
            wr_beat  = 0;
        end else begin
            ready_o  <= heavy_drop_i ? (take_bits(1) != 0) : (take_bits(3) != 0);
            rvalid_o <= 1'b0;
            if (write_i && ready_o) begin
                wr_line[wr_beat*mem_pkg::BEAT_WIDTH +: mem_pkg::BEAT_WIDTH] = wdata_i;
                if (wr_beat == mem_pkg::BURSTS_PER_LINE - 1) begin
                    mem[addr_i] = wr_line;
                    wr_beat     = 0;
                end else begin
                    wr_beat++;
                end
            end
            if (read_i && ready_o) begin
                rd_addr  = addr_i;
                rd_line  = stored_line(addr_i);
                rd_busy  = 1'b1;
                rd_beat  = 0;
                wait_cnt = int'(take_bits(3));   // first beat latency
            end else if (rd_busy) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else begin
                    rvalid_o <= 1'b1;
                    raddr_o  <= rd_addr;
                    rdata_o  <= rd_line[rd_beat*mem_pkg::BEAT_WIDTH +: mem_pkg::BEAT_WIDTH];
                    wait_cnt = int'(take_bits(2));   // gap before the next beat
                    if (rd_beat == mem_pkg::BURSTS_PER_LINE - 1) begin
                        rd_busy = 1'b0;
                    end else begin
                        rd_beat++;
                    end
                end
            end
        end
    end

endmodule : bmem_model

/* tests/tb_cache_mem_ctrl.sv */
module tb_cache_mem_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_IREAD  = 8;
    localparam int N_WBACK  = 4;    // three requests each
    localparam int N_PRIO   = 4;    // two requests each
    localparam int N_BP     = 6;    // two requests each
    localparam int N_MIXED  = 40;
    localparam int TOTAL_REQS = N_IREAD + 3*N_WBACK + 2*N_PRIO + 2*N_BP + N_MIXED;
    localparam mem_pkg::addr_t REGION = 32'h8000_0000;   // small area so lines get reused

    logic           clk;
    logic           rst;
    mem_pkg::addr_t i_addr;
    logic           i_read;
    mem_pkg::line_t i_rdata;
    logic           i_resp;
    mem_pkg::addr_t d_addr;
    logic           d_read;
    logic           d_write;
    mem_pkg::line_t d_wdata;
    mem_pkg::line_t d_rdata;
    logic           d_resp;
    mem_pkg::addr_t bmem_addr;
    logic           bmem_read;
    logic           bmem_write;
    mem_pkg::beat_t bmem_wdata;
    logic           bmem_ready;
    mem_pkg::addr_t bmem_raddr;
    mem_pkg::beat_t bmem_rdata;
    logic           bmem_rvalid;
    logic           heavy_drop;

    int             i_resp_cnt = 0;
    int             d_resp_cnt = 0;
    time            i_resp_t = 0;
    time            d_resp_t = 0;
    int             err_cnt = 0;
    int             test_err = 0;
    int             tests_pass = 0;
    int             tests_fail = 0;
    logic [31:0]    lfsr_q = 32'h19e5_44a8;
    mem_pkg::line_t ref_mem [mem_pkg::addr_t];

    cache_mem_ctrl dut_i (
        .clk (clk), .rst (rst),
        .i_addr_i (i_addr), .i_read_i (i_read), .i_rdata_o (i_rdata), .i_resp_o (i_resp),
        .d_addr_i (d_addr), .d_read_i (d_read), .d_write_i (d_write),
        .d_wdata_i (d_wdata), .d_rdata_o (d_rdata), .d_resp_o (d_resp),
        .bmem_addr_o (bmem_addr), .bmem_read_o (bmem_read), .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata), .bmem_ready_i (bmem_ready), .bmem_raddr_i (bmem_raddr),
        .bmem_rdata_i (bmem_rdata), .bmem_rvalid_i (bmem_rvalid)
    );

    bmem_model mem_i (
        .clk (clk), .rst (rst), .addr_i (bmem_addr), .read_i (bmem_read),
        .write_i (bmem_write), .wdata_i (bmem_wdata), .heavy_drop_i (heavy_drop),
        .ready_o (bmem_ready), .raddr_o (bmem_raddr), .rdata_o (bmem_rdata),
        .rvalid_o (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // responses counted at the falling edge, where they are stable
    always @(negedge clk) begin
        if (i_resp) begin
            i_resp_cnt++;
            i_resp_t = $time;
        end
        if (d_resp) begin
            d_resp_cnt++;
            d_resp_t = $time;
        end
    end

    initial begin
        repeat (TOTAL_REQS * 200) @(posedge clk);
        $display("watchdog: no response within %0d cycles, the run is stuck", TOTAL_REQS * 200);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic mem_pkg::addr_t rand_addr(input int bits);
        logic [31:0] idx;
        idx = rand_bits(bits);
        return idx << mem_pkg::LINE_OFFSET_BITS;
    endfunction

    function automatic mem_pkg::line_t rand_line();
        mem_pkg::line_t line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = rand_bits(32);
        end
        return line;
    endfunction

    // reference copy of memory, fill pattern where nothing was written
    function automatic mem_pkg::line_t expected_line(input mem_pkg::addr_t addr);
        mem_pkg::line_t line;
        logic [31:0]    word;
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        for (int b = 0; b < mem_pkg::BURSTS_PER_LINE; b++) begin
            word = (addr >> mem_pkg::LINE_OFFSET_BITS) * 4 + b;
            line[b*mem_pkg::BEAT_WIDTH +: mem_pkg::BEAT_WIDTH] = {word, word};
        end
        return line;
    endfunction

    task automatic check_line(input string name, input mem_pkg::line_t exp,
                              input mem_pkg::line_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_resp_order(input string name, input logic exp_d_first,
                                    input logic act_d_first);
        if (act_d_first !== exp_d_first) begin
            $display("** Error %s: expected %s, actual %s", name,
                     exp_d_first ? "d first" : "i first", act_d_first ? "d first" : "i first");
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err) begin
            $display("%s: pass", name);
            tests_pass++;
        end else begin
            $display("%s: fail with %0d errors", name, err_cnt - test_err);
            tests_fail++;
        end
        test_err = err_cnt;
    endtask

    // start at a drive point, return at the next one with the request dropped
    task automatic read_i_line(input mem_pkg::addr_t addr, output mem_pkg::line_t rdata);
        i_addr = addr;
        i_read = 1'b1;
        @(negedge clk);
        while (!i_resp) @(negedge clk);
        rdata = i_rdata;
        @(posedge clk);
        #10;
        i_read = 1'b0;
    endtask

    task automatic access_d(input logic is_write, input mem_pkg::addr_t addr,
                            input mem_pkg::line_t wdata, output mem_pkg::line_t rdata);
        d_addr  = addr;
        d_wdata = wdata;
        d_write = is_write;
        d_read  = !is_write;
        @(negedge clk);
        while (!d_resp) @(negedge clk);
        rdata = d_rdata;
        @(posedge clk);
        #10;
        d_read  = 1'b0;
        d_write = 1'b0;
    endtask

    initial begin
        mem_pkg::addr_t addr;
        mem_pkg::addr_t addr2;
        mem_pkg::line_t data;
        mem_pkg::line_t got;
        mem_pkg::line_t got2;
        logic [31:0]    kind;
        int             i_base;
        int             d_base;
        int             n_i;
        int             n_d;

        rst = 1'b1;
        i_addr = '0;
        i_read = 1'b0;
        d_addr = '0;
        d_read = 1'b0;
        d_write = 1'b0;
        d_wdata = '0;
        heavy_drop = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_flag("reset i_resp", 1'b0, i_resp);
            check_flag("reset d_resp", 1'b0, d_resp);
            check_flag("reset bmem_read", 1'b0, bmem_read);
            check_flag("reset bmem_write", 1'b0, bmem_write);
        end
        end_test("reset");
        @(posedge clk);
        #10;

        d_base = d_resp_cnt;
        repeat (N_IREAD) begin
            addr = rand_addr(27);
            read_i_line(addr, got);
            check_line("instr_read", expected_line(addr), got);
        end
        check_count("instr_read d_resp count", d_base, d_resp_cnt);
        end_test("instr_read");

        repeat (N_WBACK) begin
            addr = rand_addr(27);
            data = rand_line();
            access_d(1'b1, addr, data, got);
            ref_mem[addr] = data;
            access_d(1'b0, addr, '0, got);
            check_line("writeback d_read", expected_line(addr), got);
            read_i_line(addr, got);
            check_line("writeback i_read", expected_line(addr), got);
        end
        end_test("writeback");

        repeat (N_PRIO) begin
            addr = rand_addr(27);
            addr2 = rand_addr(27);
            fork
                read_i_line(addr, got);
                access_d(1'b0, addr2, '0, got2);
            join
            check_line("priority i_read", expected_line(addr), got);
            check_line("priority d_read", expected_line(addr2), got2);
            check_resp_order("priority order", 1'b1, d_resp_t < i_resp_t);
        end
        end_test("priority");

        heavy_drop = 1'b1;
        repeat (N_BP) begin
            addr = REGION | rand_addr(4);
            data = rand_line();
            access_d(1'b1, addr, data, got);
            ref_mem[addr] = data;
            access_d(1'b0, addr, '0, got);
            check_line("backpressure", expected_line(addr), got);
        end
        heavy_drop = 1'b0;
        end_test("backpressure");

        i_base = i_resp_cnt;
        d_base = d_resp_cnt;
        n_i = 0;
        n_d = 0;
        repeat (N_MIXED) begin
            addr = REGION | rand_addr(4);
            kind = rand_bits(2);
            if (kind == 0) begin
                read_i_line(addr, got);
                check_line("mixed i_read", expected_line(addr), got);
                n_i++;
            end else if (kind == 1) begin
                data = rand_line();
                access_d(1'b1, addr, data, got);
                ref_mem[addr] = data;
                n_d++;
            end else begin
                access_d(1'b0, addr, '0, got);
                check_line("mixed d_read", expected_line(addr), got);
                n_d++;
            end
        end
        check_count("mixed i_resp count", i_base + n_i, i_resp_cnt);
        check_count("mixed d_resp count", d_base + n_d, d_resp_cnt);
        end_test("mixed");

        $display("tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, err_cnt);
        if (tests_fail == 0 && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_cache_mem_ctrl

/* compile.f */
source/mem_pkg.sv
source/burst_reader.sv
source/burst_writer.sv
source/line_arbiter.sv
source/cache_mem_ctrl.sv
tests/bmem_model.sv
tests/tb_cache_mem_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_cache_mem_ctrl

output=$(./obj_dir/Vtb_cache_mem_ctrl) || true
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
